// File: verilog/rf_cfg_pkg.sv
package rf_cfg_pkg;

   // one register moves through the core a bit per clock
   localparam int XLEN = 32;

   // 32 general registers followed by 4 CSR slots
   localparam int NUM_REGS = 36;

   // register number as carried on the serial ports
   localparam int REG_AW = 6;

   // bit position inside a register, 0 to XLEN-1
   localparam int BIT_CNT_W = 5;

endpackage

// File: verilog/rf_cmd_pkg.sv
package rf_cmd_pkg;

   // operation carried with every parallel register command
   typedef enum logic [1:0] {
      OP_NONE  = 2'd0,
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } rf_op_t;

endpackage

// File: verilog/rf_ram.sv
`timescale 1ns/100ps

module rf_ram #(
   parameter int RAM_WIDTH = 8,
   parameter type word_t = logic [RAM_WIDTH-1:0],
   localparam int DEPTH = rf_cfg_pkg::XLEN * rf_cfg_pkg::NUM_REGS / RAM_WIDTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  logic          i_clk,
   input  logic [AW-1:0] i_waddr,
   input  word_t         i_wdata,
   input  logic          i_wen,
   input  logic [AW-1:0] i_raddr,
   output word_t         o_rdata
);

   word_t mem [DEPTH];

   always_ff @(posedge i_clk) begin
      if (i_wen)
         mem[i_waddr] <= i_wdata;
      o_rdata <= mem[i_raddr];
   end

   // register numbers above the CSR slots would land past the end
   assert property (@(posedge i_clk)
      (i_raddr < AW'(DEPTH)) && (!i_wen || i_waddr < AW'(DEPTH)));

endmodule

// File: verilog/serial_rf_ram_if.sv
`timescale 1ns/100ps

module serial_rf_ram_if #(
   parameter int RAM_WIDTH = 8,
   localparam int DEPTH = rf_cfg_pkg::XLEN * rf_cfg_pkg::NUM_REGS / RAM_WIDTH,
   localparam int AW = $clog2(DEPTH)
) (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_wreq,
   input  logic                          i_rreq,
   output logic                          o_ready,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_wreg0,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_wreg1,
   input  logic                          i_wen0,
   input  logic                          i_wen1,
   input  logic                          i_wdata0,
   input  logic                          i_wdata1,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_rreg0,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_rreg1,
   output logic                          o_rdata0,
   output logic                          o_rdata1,
   output logic [AW-1:0]                 o_waddr,
   output logic [RAM_WIDTH-1:0]          o_wdata,
   output logic                          o_wen,
   output logic [AW-1:0]                 o_raddr,
   input  logic [RAM_WIDTH-1:0]          i_rdata
);

   import rf_cfg_pkg::*;

   localparam int L2W = $clog2(RAM_WIDTH);

   logic                 wgo;
   logic                 wact;
   logic [BIT_CNT_W-1:0] wcnt;
   logic [BIT_CNT_W-1:0] wcnt_r;
   logic [BIT_CNT_W-1:0] wpos;
   logic                 wtrig0;
   logic                 wtrig1;
   logic [REG_AW-1:0]    wreg;
   logic [RAM_WIDTH-2:0] wdata0_r;
   logic [RAM_WIDTH-1:0] wdata0_full;
   logic [RAM_WIDTH-1:0] wdata1_r;

   logic                 rreq_r;
   logic                 rgnt;
   logic [BIT_CNT_W-1:0] rcnt;
   logic [BIT_CNT_W-1:0] rpos;
   logic [BIT_CNT_W-1:0] rpos_next;
   logic [BIT_CNT_W-1:0] raddr_pos;
   logic                 rfetch0;
   logic                 rfetch1;
   logic                 rtrig0;
   logic                 rtrig1;
   logic [REG_AW-1:0]    rreg;
   logic [RAM_WIDTH-1:0] rdata0;
   logic [RAM_WIDTH-2:0] rdata1;

   // write grant is immediate and read grant comes two cycles after the request
   assign o_ready = rgnt | i_wreq;

   // wcnt equals the index of the write bit on i_wdata0/1
   assign wact = i_wreq | wgo;
   assign wtrig0 = wact & (&wcnt[L2W-1:0]);

   // port 0 word goes out as its last bit arrives and port 1 one cycle later
   assign wdata0_full = {i_wdata0, wdata0_r};
   assign o_wdata = wtrig1 ? wdata1_r : wdata0_full;
   assign wreg = wtrig1 ? i_wreg1 : i_wreg0;
   assign wpos = wtrig1 ? wcnt_r : wcnt;
   assign o_waddr = AW'({wreg, wpos} >> L2W);
   assign o_wen = (wtrig0 & i_wen0) | (wtrig1 & i_wen1);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wgo    <= 1'b0;
         wcnt   <= '0;
         wtrig1 <= 1'b0;
      end else begin
         wtrig1 <= wtrig0;
         if (wact)
            wcnt <= wcnt + 1'b1;
         if (i_wreq)
            wgo <= 1'b1;
         else if (wcnt == '1)
            wgo <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      wcnt_r   <= wcnt;
      wdata0_r <= wdata0_full[RAM_WIDTH-1:1];
      wdata1_r <= {i_wdata1, wdata1_r[RAM_WIDTH-1:1]};
   end

   // port 0 read word is fetched two cycles ahead of its first bit
   // and port 1 one cycle ahead so the fetches never collide
   assign rpos = i_rreq ? '1 : rcnt;
   assign rpos_next = rpos + 1'b1;
   assign rfetch0 = &rpos[L2W-1:0];
   assign rfetch1 = ~|rpos[L2W-1:0];
   assign rreg = rfetch0 ? i_rreg0 : i_rreg1;
   assign raddr_pos = rfetch0 ? rpos_next : rpos;
   assign o_raddr = AW'({rreg, raddr_pos} >> L2W);

   assign o_rdata0 = rdata0[0];
   // first bit of a port 1 word comes straight from the RAM
   assign o_rdata1 = rtrig1 ? i_rdata[0] : rdata1[0];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rreq_r <= 1'b0;
         rgnt   <= 1'b0;
         rcnt   <= '0;
         rtrig0 <= 1'b0;
         rtrig1 <= 1'b0;
      end else begin
         rreq_r <= i_rreq;
         rgnt   <= rreq_r;
         rtrig0 <= rfetch0;
         rtrig1 <= rfetch1;
         if (i_rreq)
            rcnt <= '0;
         else
            rcnt <= rcnt + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (rtrig0)
         rdata0 <= i_rdata;
      else
         rdata0 <= rdata0 >> 1;
      if (rtrig1)
         rdata1 <= i_rdata[RAM_WIDTH-1:1];
      else
         rdata1 <= rdata1 >> 1;
   end

   initial begin
      assert (RAM_WIDTH >= 2 && RAM_WIDTH <= 32 && (RAM_WIDTH & (RAM_WIDTH - 1)) == 0)
         else $fatal(1, "RAM_WIDTH must be a power of two from 2 to 32");
   end

   // RAM writes only inside the window opened by a write request
   assert property (@(posedge i_clk) disable iff (i_rst)
      o_wen |-> (i_wreq || wgo || $past(wgo)));

endmodule

// File: verilog/rf_cmd_serializer.sv
`timescale 1ns/100ps

module rf_cmd_serializer #(
   parameter int NUM_LANES = 4,
   localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_cmd_valid,
   input  rf_cmd_pkg::rf_op_t            i_cmd_op,
   input  logic [LANE_W-1:0]             i_cmd_lane,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_rreg0,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_rreg1,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_wreg0,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_wreg1,
   input  logic                          i_wen0,
   input  logic                          i_wen1,
   input  logic [rf_cfg_pkg::XLEN-1:0]   i_wdata0,
   input  logic [rf_cfg_pkg::XLEN-1:0]   i_wdata1,
   input  logic [NUM_LANES-1:0]          i_ready,
   output logic [NUM_LANES-1:0]          o_rreq,
   output logic [NUM_LANES-1:0]          o_wreq,
   output logic [rf_cfg_pkg::REG_AW-1:0] o_rreg0,
   output logic [rf_cfg_pkg::REG_AW-1:0] o_rreg1,
   output logic [rf_cfg_pkg::REG_AW-1:0] o_wreg0,
   output logic [rf_cfg_pkg::REG_AW-1:0] o_wreg1,
   output logic                          o_wen0,
   output logic                          o_wen1,
   output logic                          o_wbit0,
   output logic                          o_wbit1,
   output logic [LANE_W-1:0]             o_lane,
   output logic                          o_rd_start,
   output logic                          o_busy,
   output logic                          o_done
);

   import rf_cfg_pkg::*;
   import rf_cmd_pkg::*;

   localparam int CNT_W = $clog2(XLEN + 3);

   logic            accept;
   logic            last;
   logic            rd_arm;
   rf_op_t          op_r;
   logic [CNT_W-1:0] cnt;
   logic [XLEN-1:0] wsh0;
   logic [XLEN-1:0] wsh1;

   assign accept = i_cmd_valid & ~o_busy;

   // cnt is 0 in the request cycle and done follows the cycle after last
   assign last = o_busy & (cnt == ((op_r == OP_WRITE) ? CNT_W'(XLEN + 2) : CNT_W'(XLEN + 1)));

   assign o_wbit0 = wsh0[0];
   assign o_wbit1 = wsh1[0];
   assign o_rd_start = rd_arm & i_ready[o_lane];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_busy  <= 1'b0;
         o_done  <= 1'b0;
         rd_arm  <= 1'b0;
         op_r    <= OP_NONE;
         cnt     <= '0;
         o_rreq  <= '0;
         o_wreq  <= '0;
         o_rreg0 <= '0;
         o_rreg1 <= '0;
         o_wreg0 <= '0;
         o_wreg1 <= '0;
         o_wen0  <= 1'b0;
         o_wen1  <= 1'b0;
      end else begin
         o_done <= last;
         // lane grants a read two cycles after its request
         rd_arm <= o_busy & (op_r == OP_READ) & (cnt == CNT_W'(1));
         o_rreq <= '0;
         o_wreq <= '0;
         if (accept) begin
            o_busy  <= 1'b1;
            cnt     <= '0;
            op_r    <= i_cmd_op;
            o_rreg0 <= i_rreg0;
            o_rreg1 <= i_rreg1;
            o_wreg0 <= i_wreg0;
            o_wreg1 <= i_wreg1;
            o_wen0  <= i_wen0 & (i_cmd_op == OP_WRITE);
            o_wen1  <= i_wen1 & (i_cmd_op == OP_WRITE);
            if (i_cmd_op == OP_READ)
               o_rreq[i_cmd_lane] <= 1'b1;
            if (i_cmd_op == OP_WRITE)
               o_wreq[i_cmd_lane] <= 1'b1;
         end else if (last) begin
            o_busy <= 1'b0;
         end else if (o_busy) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // write words leave LSB first with bit 0 alongside the request strobe
   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_lane <= i_cmd_lane;
         wsh0   <= i_wdata0;
         wsh1   <= i_wdata1;
      end else begin
         wsh0 <= wsh0 >> 1;
         wsh1 <= wsh1 >> 1;
      end
   end

   assert property (@(posedge i_clk) disable iff (i_rst) $onehot0({o_rreq, o_wreq}));

   // the addressed lane has to grant in the cycle the collector starts
   assert property (@(posedge i_clk) disable iff (i_rst) rd_arm |-> i_ready[o_lane]);

endmodule

// File: verilog/rf_read_collector.sv
`timescale 1ns/100ps

module rf_read_collector #(
   parameter int NUM_LANES = 4,
   localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  logic [LANE_W-1:0]           i_lane,
   input  logic                        i_rd_start,
   input  logic [NUM_LANES-1:0]        i_rbit0,
   input  logic [NUM_LANES-1:0]        i_rbit1,
   output logic [rf_cfg_pkg::XLEN-1:0] o_rdata0,
   output logic [rf_cfg_pkg::XLEN-1:0] o_rdata1,
   output logic                        o_rd_valid
);

   import rf_cfg_pkg::*;

   logic                 bit0;
   logic                 bit1;
   logic                 active;
   logic                 shift;
   logic [BIT_CNT_W-1:0] cnt;

   assign bit0 = i_rbit0[i_lane];
   assign bit1 = i_rbit1[i_lane];

   // bit 0 is already on the lane outputs when the start pulse comes
   assign shift = i_rd_start | active;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         active     <= 1'b0;
         cnt        <= '0;
         o_rd_valid <= 1'b0;
      end else begin
         o_rd_valid <= active & (cnt == BIT_CNT_W'(XLEN - 1));
         if (i_rd_start) begin
            active <= 1'b1;
            cnt    <= BIT_CNT_W'(1);
         end else if (active) begin
            cnt <= cnt + 1'b1;
            if (cnt == BIT_CNT_W'(XLEN - 1))
               active <= 1'b0;
         end
      end
   end

   // bits arrive LSB first so each new bit enters at the top
   always_ff @(posedge i_clk) begin
      if (shift) begin
         o_rdata0 <= {bit0, o_rdata0[XLEN-1:1]};
         o_rdata1 <= {bit1, o_rdata1[XLEN-1:1]};
      end
   end

endmodule

// File: verilog/serial_rf_bank.sv
`timescale 1ns/100ps

module serial_rf_bank #(
   parameter int NUM_LANES = 4,
   parameter int RAM_WIDTH = 8,
   localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_cmd_valid,
   input  rf_cmd_pkg::rf_op_t            i_cmd_op,
   input  logic [LANE_W-1:0]             i_cmd_lane,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_rreg0,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_rreg1,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_wreg0,
   input  logic [rf_cfg_pkg::REG_AW-1:0] i_wreg1,
   input  logic                          i_wen0,
   input  logic                          i_wen1,
   input  logic [rf_cfg_pkg::XLEN-1:0]   i_wdata0,
   input  logic [rf_cfg_pkg::XLEN-1:0]   i_wdata1,
   output logic                          o_busy,
   output logic                          o_done,
   output logic [rf_cfg_pkg::XLEN-1:0]   o_rdata0,
   output logic [rf_cfg_pkg::XLEN-1:0]   o_rdata1,
   output logic                          o_rd_valid
);

   import rf_cfg_pkg::*;

   localparam int DEPTH = XLEN * NUM_REGS / RAM_WIDTH;
   localparam int AW = $clog2(DEPTH);

   logic [NUM_LANES-1:0] rreq;
   logic [NUM_LANES-1:0] wreq;
   logic [NUM_LANES-1:0] ready;
   logic [NUM_LANES-1:0] rbit0;
   logic [NUM_LANES-1:0] rbit1;
   logic [REG_AW-1:0]    rreg0;
   logic [REG_AW-1:0]    rreg1;
   logic [REG_AW-1:0]    wreg0;
   logic [REG_AW-1:0]    wreg1;
   logic                 wen0;
   logic                 wen1;
   logic                 wbit0;
   logic                 wbit1;
   logic [LANE_W-1:0]    lane;
   logic                 rd_start;

   rf_cmd_serializer #(.NUM_LANES(NUM_LANES)) u_serializer (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op), .i_cmd_lane(i_cmd_lane),
      .i_rreg0(i_rreg0), .i_rreg1(i_rreg1), .i_wreg0(i_wreg0), .i_wreg1(i_wreg1),
      .i_wen0(i_wen0), .i_wen1(i_wen1), .i_wdata0(i_wdata0), .i_wdata1(i_wdata1),
      .i_ready(ready), .o_rreq(rreq), .o_wreq(wreq),
      .o_rreg0(rreg0), .o_rreg1(rreg1), .o_wreg0(wreg0), .o_wreg1(wreg1),
      .o_wen0(wen0), .o_wen1(wen1), .o_wbit0(wbit0), .o_wbit1(wbit1),
      .o_lane(lane), .o_rd_start(rd_start), .o_busy(o_busy), .o_done(o_done)
   );

   for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
      typedef logic [RAM_WIDTH-1:0] word_t;

      logic [AW-1:0] waddr;
      word_t         wdata;
      logic          wen;
      logic [AW-1:0] raddr;
      word_t         rdata;

      serial_rf_ram_if #(.RAM_WIDTH(RAM_WIDTH)) u_ram_if (
         .i_clk(i_clk), .i_rst(i_rst),
         .i_wreq(wreq[l]), .i_rreq(rreq[l]), .o_ready(ready[l]),
         .i_wreg0(wreg0), .i_wreg1(wreg1), .i_wen0(wen0), .i_wen1(wen1),
         .i_wdata0(wbit0), .i_wdata1(wbit1),
         .i_rreg0(rreg0), .i_rreg1(rreg1), .o_rdata0(rbit0[l]), .o_rdata1(rbit1[l]),
         .o_waddr(waddr), .o_wdata(wdata), .o_wen(wen),
         .o_raddr(raddr), .i_rdata(rdata)
      );

      rf_ram #(.RAM_WIDTH(RAM_WIDTH), .word_t(word_t)) u_ram (
         .i_clk(i_clk),
         .i_waddr(waddr), .i_wdata(wdata), .i_wen(wen),
         .i_raddr(raddr), .o_rdata(rdata)
      );
   end

   rf_read_collector #(.NUM_LANES(NUM_LANES)) u_collector (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_lane(lane), .i_rd_start(rd_start),
      .i_rbit0(rbit0), .i_rbit1(rbit1),
      .o_rdata0(o_rdata0), .o_rdata1(o_rdata1), .o_rd_valid(o_rd_valid)
   );

endmodule

// File: test/tb_serial_rf_bank.sv
`timescale 1ns/100ps

module tb_serial_rf_bank;

   import rf_cfg_pkg::*;
   import rf_cmd_pkg::*;

   localparam int NUM_CMDS = 16;
   // every command fits in 40 cycles with reset and some slack on top
   localparam int MAX_CYCLES = NUM_CMDS * 40 + 16 + 64;

   // flag bits select random write data (2), a second command while busy (1)
   // and a compare with exp (0)
   typedef struct packed {
      rf_op_t            op;
      logic [1:0]        lane;
      logic [REG_AW-1:0] rreg0;
      logic [REG_AW-1:0] rreg1;
      logic [REG_AW-1:0] wreg0;
      logic [REG_AW-1:0] wreg1;
      logic [1:0]        wen;
      logic [2:0]        flags;
      logic [XLEN-1:0]   wdata0;
      logic [XLEN-1:0]   wdata1;
      logic [XLEN-1:0]   exp0;
      logic [XLEN-1:0]   exp1;
   } cmd_t;

   localparam cmd_t CMDS [NUM_CMDS] = '{
      '{OP_WRITE, 2'd0, 6'd0, 6'd0, 6'd5, 6'd0, 2'b01, 3'b000,
        32'hdeadbeef, 32'h0, 32'h0, 32'h0},
      '{OP_READ, 2'd0, 6'd5, 6'd5, 6'd0, 6'd0, 2'b00, 3'b001,
        32'h0, 32'h0, 32'hdeadbeef, 32'hdeadbeef},
      '{OP_WRITE, 2'd1, 6'd0, 6'd0, 6'd7, 6'd33, 2'b11, 3'b000,
        32'h12345678, 32'ha5a50f0f, 32'h0, 32'h0},
      '{OP_READ, 2'd1, 6'd7, 6'd33, 6'd0, 6'd0, 2'b00, 3'b001,
        32'h0, 32'h0, 32'h12345678, 32'ha5a50f0f},
      '{OP_WRITE, 2'd1, 6'd0, 6'd0, 6'd7, 6'd33, 2'b10, 3'b000,
        32'hffffffff, 32'h0badc0de, 32'h0, 32'h0},
      '{OP_READ, 2'd1, 6'd7, 6'd33, 6'd0, 6'd0, 2'b00, 3'b001,
        32'h0, 32'h0, 32'h12345678, 32'h0badc0de},
      '{OP_WRITE, 2'd2, 6'd0, 6'd0, 6'd5, 6'd0, 2'b01, 3'b000,
        32'h22222222, 32'h0, 32'h0, 32'h0},
      '{OP_WRITE, 2'd3, 6'd0, 6'd0, 6'd5, 6'd35, 2'b11, 3'b000,
        32'h33333333, 32'h80000001, 32'h0, 32'h0},
      '{OP_READ, 2'd2, 6'd5, 6'd5, 6'd0, 6'd0, 2'b00, 3'b001,
        32'h0, 32'h0, 32'h22222222, 32'h22222222},
      '{OP_READ, 2'd3, 6'd5, 6'd35, 6'd0, 6'd0, 2'b00, 3'b001,
        32'h0, 32'h0, 32'h33333333, 32'h80000001},
      '{OP_READ, 2'd1, 6'd33, 6'd7, 6'd0, 6'd0, 2'b00, 3'b011,
        32'h0, 32'h0, 32'h0badc0de, 32'h12345678},
      '{OP_WRITE, 2'd0, 6'd0, 6'd34, 6'd0, 6'd34, 2'b11, 3'b110,
        32'h0, 32'h0, 32'h0, 32'h0},
      '{OP_READ, 2'd0, 6'd0, 6'd34, 6'd0, 6'd0, 2'b00, 3'b000,
        32'h0, 32'h0, 32'h0, 32'h0},
      '{OP_READ, 2'd1, 6'd7, 6'd33, 6'd0, 6'd0, 2'b00, 3'b001,
        32'h0, 32'h0, 32'h12345678, 32'h0badc0de},
      '{OP_WRITE, 2'd2, 6'd0, 6'd0, 6'd31, 6'd32, 2'b11, 3'b100,
        32'h0, 32'h0, 32'h0, 32'h0},
      '{OP_READ, 2'd2, 6'd31, 6'd32, 6'd0, 6'd0, 2'b00, 3'b000,
        32'h0, 32'h0, 32'h0, 32'h0}
   };

   logic              i_clk;
   logic              i_rst;
   logic              i_cmd_valid;
   rf_op_t            i_cmd_op;
   logic [1:0]        i_cmd_lane;
   logic [REG_AW-1:0] i_rreg0;
   logic [REG_AW-1:0] i_rreg1;
   logic [REG_AW-1:0] i_wreg0;
   logic [REG_AW-1:0] i_wreg1;
   logic              i_wen0;
   logic              i_wen1;
   logic [XLEN-1:0]   i_wdata0;
   logic [XLEN-1:0]   i_wdata1;
   logic              o_busy;
   logic              o_done;
   logic [XLEN-1:0]   o_rdata0;
   logic [XLEN-1:0]   o_rdata1;
   logic              o_rd_valid;

   logic [XLEN-1:0] model [4][NUM_REGS];
   logic [31:0]     rng = 32'hfeb8529c;
   int              cycles = 0;
   int              checks = 0;
   int              errors = 0;

   serial_rf_bank #(.NUM_LANES(4), .RAM_WIDTH(8)) dut0 (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_cmd_valid(i_cmd_valid), .i_cmd_op(i_cmd_op), .i_cmd_lane(i_cmd_lane),
      .i_rreg0(i_rreg0), .i_rreg1(i_rreg1), .i_wreg0(i_wreg0), .i_wreg1(i_wreg1),
      .i_wen0(i_wen0), .i_wen1(i_wen1), .i_wdata0(i_wdata0), .i_wdata1(i_wdata1),
      .o_busy(o_busy), .o_done(o_done), .o_rdata0(o_rdata0), .o_rdata1(o_rdata1),
      .o_rd_valid(o_rd_valid)
   );

   always #20 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("run timed out after %0d cycles waiting for the DUT", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // xorshift32
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic drive_cmd(input rf_op_t op, input logic [1:0] lane,
                            input logic [REG_AW-1:0] rreg0, input logic [REG_AW-1:0] rreg1,
                            input logic [REG_AW-1:0] wreg0, input logic [REG_AW-1:0] wreg1,
                            input logic [1:0] wen, input logic [XLEN-1:0] wd0,
                            input logic [XLEN-1:0] wd1);
      i_cmd_valid = 1'b1;
      i_cmd_op    = op;
      i_cmd_lane  = lane;
      i_rreg0     = rreg0;
      i_rreg1     = rreg1;
      i_wreg0     = wreg0;
      i_wreg1     = wreg1;
      i_wen0      = wen[0];
      i_wen1      = wen[1];
      i_wdata0    = wd0;
      i_wdata1    = wd1;
   endtask

   task automatic run_cmd(input int idx);
      cmd_t            c;
      logic [XLEN-1:0] wd0;
      logic [XLEN-1:0] wd1;
      logic [XLEN-1:0] got0;
      logic [XLEN-1:0] got1;
      int              n;
      int              rv_n;
      int              rv_cnt;
      int              busy_low;
      c = CMDS[idx];
      wd0 = c.wdata0;
      wd1 = c.wdata1;
      if (c.flags[2]) begin
         wd0 = next_rand();
         wd1 = next_rand();
      end
      n = 0;
      rv_n = 0;
      rv_cnt = 0;
      busy_low = 0;
      got0 = '0;
      got1 = '0;
      drive_cmd(c.op, c.lane, c.rreg0, c.rreg1, c.wreg0, c.wreg1, c.wen, wd0, wd1);
      do begin
         @(posedge i_clk);
         #2;
         n++;
         if (n == 1 || n == 5)
            i_cmd_valid = 1'b0;
         // overwrite attempt on the same registers has to be dropped
         if (c.flags[1] && n == 4)
            drive_cmd(OP_WRITE, c.lane, c.rreg0, c.rreg1, c.rreg0, c.rreg1, 2'b11,
                      next_rand(), next_rand());
         if (o_rd_valid) begin
            rv_cnt++;
            rv_n = n;
            got0 = o_rdata0;
            got1 = o_rdata1;
         end
         // busy holds from acceptance until done
         if (o_done !== 1'b1 && o_busy !== 1'b1)
            busy_low++;
      end while (o_done !== 1'b1);
      check(n, (c.op == OP_WRITE) ? 36 : 35, $sformatf("cmd %0d done latency", idx));
      check(busy_low, 0, $sformatf("cmd %0d busy low before done", idx));
      if (c.op == OP_READ) begin
         check(rv_cnt, 1, $sformatf("cmd %0d read valid pulses", idx));
         check(rv_n, 35, $sformatf("cmd %0d read valid latency", idx));
         check(got0, model[c.lane][c.rreg0], $sformatf("cmd %0d rdata0 vs model", idx));
         check(got1, model[c.lane][c.rreg1], $sformatf("cmd %0d rdata1 vs model", idx));
         if (c.flags[0]) begin
            check(got0, c.exp0, $sformatf("cmd %0d rdata0 vs table", idx));
            check(got1, c.exp1, $sformatf("cmd %0d rdata1 vs table", idx));
         end
      end else begin
         check(rv_cnt, 0, $sformatf("cmd %0d read valid on write", idx));
         // port 1 lands after port 0
         if (c.wen[0])
            model[c.lane][c.wreg0] = wd0;
         if (c.wen[1])
            model[c.lane][c.wreg1] = wd1;
      end
      @(posedge i_clk);
      #2;
      check(32'(o_done), 0, $sformatf("cmd %0d done pulse width", idx));
      check(32'(o_busy), 0, $sformatf("cmd %0d busy after done", idx));
      check(32'(o_rd_valid), 0, $sformatf("cmd %0d read valid after done", idx));
   endtask

   initial begin
      i_clk = 1'b0;
      i_rst = 1'b1;
      drive_cmd(OP_NONE, 2'd0, '0, '0, '0, '0, 2'b00, '0, '0);
      i_cmd_valid = 1'b0;
      repeat (16) @(posedge i_clk);
      #2;
      i_rst = 1'b0;
      check(32'(o_busy), 0, "busy after reset");
      check(32'(o_done), 0, "done after reset");
      check(32'(o_rd_valid), 0, "read valid after reset");
      for (int i = 0; i < NUM_CMDS; i++)
         run_cmd(i);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// File: serial_rf_bank.f
verilog/rf_cfg_pkg.sv
verilog/rf_cmd_pkg.sv
verilog/rf_ram.sv
verilog/serial_rf_ram_if.sv
verilog/rf_cmd_serializer.sv
verilog/rf_read_collector.sv
verilog/serial_rf_bank.sv
test/tb_serial_rf_bank.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_serial_rf_bank
FILELIST  ?= serial_rf_bank.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
